//--- ecc_pkg.sv
package ecc_pkg;

  // Code geometry for 32-bit Hsiao SECDED
  localparam int unsigned data_width = 32;
  localparam int unsigned parity_width = 7;
  localparam int unsigned codeword_width = data_width + parity_width;
  // Enough bits to address any of the 39 codeword bits
  localparam int unsigned bit_idx_width = 6;
  // Event counter width
  localparam int unsigned count_width = 16;

  // Codeword layout
  // Bits 31..0 carry data, bits 38..32 carry parity
  typedef struct packed {
    logic [parity_width-1:0] parity;
    logic [data_width-1:0]   data;
  } ecc_codeword_t;

  // Fault injection modes
  typedef enum logic [1:0] {
    inj_none   = 2'd0,
    inj_single = 2'd1,
    inj_double = 2'd2
  } ecc_inj_mode_e;

  // Injection command, travels alongside the data
  typedef struct packed {
    ecc_inj_mode_e            mode;
    logic [bit_idx_width-1:0] bit0;
    logic [bit_idx_width-1:0] bit1;
  } ecc_inj_t;

  // Decoded word plus error report
  typedef struct packed {
    logic [data_width-1:0]   data;
    logic [parity_width-1:0] syndrome;
    // Single error seen and fixed
    logic                    ce;
    // Detected, uncorrectable
    logic                    due;
  } ecc_dec_result_t;

  // Parity-check column for data bit idx
  // Weight-three patterns in ascending order, idx picks the idx-th one
  // 35 such patterns exist, the first 32 are in use
  function automatic logic [parity_width-1:0] hsiao_column(input int unsigned idx);
    logic [parity_width-1:0] col;
    int unsigned             found;
    col = '0;
    found = 0;
    // Walk all 7-bit values, counting weight-three hits
    for (int v = 0; v < (1 << parity_width); v++) begin
      if ($countones(v[parity_width-1:0]) == 3) begin
        if (found == idx) begin
          col = v[parity_width-1:0];
        end
        found++;
      end
    end
    return col;
  endfunction

endpackage

//--- ecc_secded_encoder.sv
`timescale 1ns/1ps

module ecc_secded_encoder #(
  parameter bit register_inputs = 0,
  parameter bit register_outputs = 0
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           in_valid,
  input  logic [ecc_pkg::data_width-1:0] in_data,
  input  ecc_pkg::ecc_inj_t              in_inj,
  output logic                           enc_valid,
  output ecc_pkg::ecc_codeword_t         enc_codeword,
  output ecc_pkg::ecc_inj_t              enc_inj
);

  // Data word and its injection command
  typedef struct packed {
    logic [ecc_pkg::data_width-1:0] data;
    ecc_pkg::ecc_inj_t              inj;
  } enc_in_t;

  // Finished codeword, command still attached
  typedef struct packed {
    ecc_pkg::ecc_codeword_t codeword;
    ecc_pkg::ecc_inj_t      inj;
  } enc_out_t;

  enc_in_t                          src_in;
  enc_in_t                          stg_in;
  logic                             stg_valid;
  logic [ecc_pkg::parity_width-1:0] parity;
  enc_out_t                         comb_out;
  enc_out_t                         final_out;

  assign src_in.data = in_data;
  assign src_in.inj  = in_inj;

  // Optional input stage
  if (register_inputs) begin : gen_in_reg
    logic    in_valid_q;
    enc_in_t in_q;
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        in_valid_q <= 1'b0;
      end else begin
        in_valid_q <= in_valid;
      end
    end
    // Payload loads only on valid
    always_ff @(posedge clk) begin
      if (in_valid) begin
        in_q <= src_in;
      end
    end
    assign stg_valid = in_valid_q;
    assign stg_in    = in_q;
  end else begin : gen_in_bypass
    assign stg_valid = in_valid;
    assign stg_in    = src_in;
  end

  // Each set data bit folds its column into the parity
  always_comb begin
    parity = '0;
    for (int i = 0; i < ecc_pkg::data_width; i++) begin
      if (stg_in.data[i]) begin
        parity ^= ecc_pkg::hsiao_column(i);
      end
    end
  end

  assign comb_out.codeword.data   = stg_in.data;
  assign comb_out.codeword.parity = parity;
  assign comb_out.inj             = stg_in.inj;

  // Optional output stage
  if (register_outputs) begin : gen_out_reg
    logic     out_valid_q;
    enc_out_t out_q;
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        out_valid_q <= 1'b0;
      end else begin
        out_valid_q <= stg_valid;
      end
    end
    always_ff @(posedge clk) begin
      if (stg_valid) begin
        out_q <= comb_out;
      end
    end
    assign enc_valid = out_valid_q;
    assign final_out = out_q;
  end else begin : gen_out_bypass
    assign enc_valid = stg_valid;
    assign final_out = comb_out;
  end

  assign enc_codeword = final_out.codeword;
  assign enc_inj      = final_out.inj;

endmodule

//--- ecc_error_injector.sv
`timescale 1ns/1ps

module ecc_error_injector (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   enc_valid,
  input  ecc_pkg::ecc_codeword_t enc_codeword,
  input  ecc_pkg::ecc_inj_t      enc_inj,
  output logic                   inj_valid,
  output ecc_pkg::ecc_codeword_t inj_codeword
);

  logic                               flip0;
  logic                               flip1;
  logic [ecc_pkg::codeword_width-1:0] flip_mask;
  logic                               valid_q;
  ecc_pkg::ecc_codeword_t             codeword_q;

  // Which of the two indices are active
  always_comb begin
    flip0 = 1'b0;
    flip1 = 1'b0;
    case (enc_inj.mode)
      ecc_pkg::inj_none: begin
        flip0 = 1'b0;
        flip1 = 1'b0;
      end
      ecc_pkg::inj_single: begin
        flip0 = 1'b1;
      end
      ecc_pkg::inj_double: begin
        flip0 = 1'b1;
        flip1 = 1'b1;
      end
      default: begin
        flip0 = 1'b0;
        flip1 = 1'b0;
      end
    endcase
  end

  // One-hot decode of each index, merged into one mask
  always_comb begin
    for (int k = 0; k < ecc_pkg::codeword_width; k++) begin
      flip_mask[k] = (flip0 && (enc_inj.bit0 == k)) || (flip1 && (enc_inj.bit1 == k));
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= enc_valid;
    end
  end

  // Faulted word
  always_ff @(posedge clk) begin
    if (enc_valid) begin
      codeword_q <= enc_codeword ^ flip_mask;
    end
  end

  assign inj_valid    = valid_q;
  assign inj_codeword = codeword_q;

  // Stimulus must keep flip indices inside the codeword
  bit0_in_range_a : assert property (@(posedge clk) disable iff (!arst_n)
    (enc_valid && enc_inj.mode != ecc_pkg::inj_none) |->
      (enc_inj.bit0 < ecc_pkg::codeword_width));

  // Double mode needs two distinct in-range bits
  double_distinct_a : assert property (@(posedge clk) disable iff (!arst_n)
    (enc_valid && enc_inj.mode == ecc_pkg::inj_double) |->
      (enc_inj.bit1 < ecc_pkg::codeword_width) && (enc_inj.bit1 != enc_inj.bit0));

endmodule

//--- ecc_secded_decoder.sv
`timescale 1ns/1ps

module ecc_secded_decoder #(
  parameter bit register_inputs = 0,
  parameter bit register_syndrome = 0,
  parameter bit register_outputs = 0
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     rcv_valid,
  input  ecc_pkg::ecc_codeword_t   rcv_codeword,
  output logic                     dec_valid,
  output ecc_pkg::ecc_dec_result_t dec_result
);

  // Received word with its syndrome
  typedef struct packed {
    ecc_pkg::ecc_codeword_t           codeword;
    logic [ecc_pkg::parity_width-1:0] syndrome;
  } syn_stage_t;

  logic                               in_valid;
  ecc_pkg::ecc_codeword_t             in_codeword;
  logic [ecc_pkg::parity_width-1:0]   recomputed;
  syn_stage_t                         syn_comb;
  logic                               syn_valid;
  syn_stage_t                         syn_stg;
  logic [ecc_pkg::codeword_width-1:0] hit;
  ecc_pkg::ecc_dec_result_t           result_comb;

  // Column of codeword bit k
  // Data bits use the Hsiao columns, parity bits a unit vector
  function automatic logic [ecc_pkg::parity_width-1:0] codeword_column(input int unsigned k);
    logic [ecc_pkg::parity_width-1:0] col;
    if (k < ecc_pkg::data_width) begin
      col = ecc_pkg::hsiao_column(k);
    end else begin
      col = ecc_pkg::parity_width'(1) << (k - ecc_pkg::data_width);
    end
    return col;
  endfunction

  // Optional input stage
  if (register_inputs) begin : gen_in_reg
    logic                   valid_q;
    ecc_pkg::ecc_codeword_t codeword_q;
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= rcv_valid;
      end
    end
    always_ff @(posedge clk) begin
      if (rcv_valid) begin
        codeword_q <= rcv_codeword;
      end
    end
    assign in_valid    = valid_q;
    assign in_codeword = codeword_q;
  end else begin : gen_in_bypass
    assign in_valid    = rcv_valid;
    assign in_codeword = rcv_codeword;
  end

  // Parity rebuilt from received data
  always_comb begin
    recomputed = '0;
    for (int i = 0; i < ecc_pkg::data_width; i++) begin
      if (in_codeword.data[i]) begin
        recomputed ^= ecc_pkg::hsiao_column(i);
      end
    end
  end

  // Received parity bits add their unit columns
  assign syn_comb.codeword = in_codeword;
  assign syn_comb.syndrome = recomputed ^ in_codeword.parity;

  // Optional syndrome stage
  if (register_syndrome) begin : gen_syn_reg
    logic       valid_q;
    syn_stage_t syn_q;
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= in_valid;
      end
    end
    always_ff @(posedge clk) begin
      if (in_valid) begin
        syn_q <= syn_comb;
      end
    end
    assign syn_valid = valid_q;
    assign syn_stg   = syn_q;
  end else begin : gen_syn_bypass
    assign syn_valid = in_valid;
    assign syn_stg   = syn_comb;
  end

  // Match syndrome against every column
  // At most one hit since all columns differ
  always_comb begin
    for (int k = 0; k < ecc_pkg::codeword_width; k++) begin
      hit[k] = (syn_stg.syndrome == codeword_column(k));
    end
  end

  // Parity hits still count as corrected, data untouched
  assign result_comb.data     = syn_stg.codeword.data ^ hit[ecc_pkg::data_width-1:0];
  assign result_comb.syndrome = syn_stg.syndrome;
  assign result_comb.ce       = |hit;
  // Nonzero and matching no column
  assign result_comb.due      = (syn_stg.syndrome != '0) && !(|hit);

  // Distinct columns leave at most one match, so ce and due stay exclusive
  one_hit_a : assert property (@(posedge clk) disable iff (!arst_n)
    syn_valid |-> $onehot0(hit));

  // Optional output stage
  if (register_outputs) begin : gen_out_reg
    logic                     valid_q;
    ecc_pkg::ecc_dec_result_t result_q;
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= syn_valid;
      end
    end
    always_ff @(posedge clk) begin
      if (syn_valid) begin
        result_q <= result_comb;
      end
    end
    assign dec_valid  = valid_q;
    assign dec_result = result_q;
  end else begin : gen_out_bypass
    assign dec_valid  = syn_valid;
    assign dec_result = result_comb;
  end

endmodule

//--- ecc_error_counters.sv
`timescale 1ns/1ps

module ecc_error_counters (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            dec_valid,
  input  logic                            ce,
  input  logic                            due,
  input  logic                            clear,
  output logic [ecc_pkg::count_width-1:0] ce_count,
  output logic [ecc_pkg::count_width-1:0] due_count
);

  // Slot 0 tracks ce, slot 1 tracks due
  localparam int unsigned num_counters = 2;

  logic [num_counters-1:0]         event_hit;
  logic [ecc_pkg::count_width-1:0] count_q [num_counters];

  // Events only count on valid results
  assign event_hit = {due, ce} & {num_counters{dec_valid}};

  for (genvar g = 0; g < num_counters; g++) begin : gen_counter
    // Clear beats increment, saturate at all ones
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        count_q[g] <= '0;
      end else if (clear) begin
        count_q[g] <= '0;
      end else if (event_hit[g] && (count_q[g] != '1)) begin
        count_q[g] <= count_q[g] + 1'b1;
      end
    end

    // A full counter stays full until cleared
    no_wrap_a : assert property (@(posedge clk) disable iff (!arst_n)
      ((count_q[g] == '1) && !clear) |=> (count_q[g] == '1));
  end

  assign ce_count  = count_q[0];
  assign due_count = count_q[1];

endmodule

//--- ecc_secded_path.sv
`timescale 1ns/1ps

module ecc_secded_path (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            in_valid,
  input  logic [ecc_pkg::data_width-1:0]  in_data,
  input  ecc_pkg::ecc_inj_t               in_inj,
  input  logic                            clear,
  output logic                            out_valid,
  output ecc_pkg::ecc_dec_result_t        out_result,
  output logic [ecc_pkg::count_width-1:0] ce_count,
  output logic [ecc_pkg::count_width-1:0] due_count
);

  // Stage registers, four cycles in to out
  localparam bit enc_register_inputs = 1'b0;
  localparam bit enc_register_outputs = 1'b1;
  localparam bit dec_register_inputs = 1'b0;
  localparam bit dec_register_syndrome = 1'b1;
  localparam bit dec_register_outputs = 1'b1;

  logic                   enc_valid;
  ecc_pkg::ecc_codeword_t enc_codeword;
  ecc_pkg::ecc_inj_t      enc_inj;
  logic                   inj_valid;
  ecc_pkg::ecc_codeword_t inj_codeword;

  // Parity generation, command rides along
  ecc_secded_encoder #(
    .register_inputs (enc_register_inputs),
    .register_outputs(enc_register_outputs)
  ) i_encoder (
    .clk,
    .arst_n,
    .in_valid,
    .in_data,
    .in_inj,
    .enc_valid,
    .enc_codeword,
    .enc_inj
  );

  // Bit flips
  ecc_error_injector i_injector (
    .clk,
    .arst_n,
    .enc_valid,
    .enc_codeword,
    .enc_inj,
    .inj_valid,
    .inj_codeword
  );

  ecc_secded_decoder #(
    .register_inputs  (dec_register_inputs),
    .register_syndrome(dec_register_syndrome),
    .register_outputs (dec_register_outputs)
  ) i_decoder (
    .clk,
    .arst_n,
    .rcv_valid   (inj_valid),
    .rcv_codeword(inj_codeword),
    .dec_valid   (out_valid),
    .dec_result  (out_result)
  );

  // Event tallies, one cycle behind out_valid
  ecc_error_counters i_counters (
    .clk,
    .arst_n,
    .dec_valid(out_valid),
    .ce       (out_result.ce),
    .due      (out_result.due),
    .clear,
    .ce_count,
    .due_count
  );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int half_period = 4,
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic arst_n
);

  // Reset held low, released on a rising edge
  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    arst_n <= 1'b1;
  end

  // 8 ns period
  always #half_period clk = ~clk;

endmodule

//--- tb_ecc_checker.sv
`timescale 1ns/1ps

module tb_ecc_checker (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            in_valid,
  input  logic [ecc_pkg::data_width-1:0]  in_data,
  input  ecc_pkg::ecc_inj_t               in_inj,
  input  logic                            clear,
  input  logic                            out_valid,
  input  ecc_pkg::ecc_dec_result_t        out_result,
  input  logic [ecc_pkg::count_width-1:0] ce_count,
  input  logic [ecc_pkg::count_width-1:0] due_count,
  input  logic                            report,
  output logic                            idle,
  output int unsigned                     error_count
);

  // Item in flight, with the cycle its result is due
  typedef struct packed {
    logic [31:0]       data;
    ecc_pkg::ecc_inj_t inj;
    logic [31:0]       due_cycle;
  } pending_t;

  logic [6:0]  col_table [39];
  pending_t    pending_q [$];
  logic [31:0] cycle;
  int unsigned value_errors;
  int unsigned order_errors;
  logic [15:0] exp_ce_count;
  logic [15:0] exp_due_count;

  assign error_count = value_errors + order_errors;

  // Column table, weight-three values in ascending order, then unit vectors
  initial begin
    int unsigned found;
    int unsigned ones;
    logic [6:0]  v7;
    found = 0;
    for (int v = 0; v < 128; v++) begin
      v7 = v[6:0];
      ones = 0;
      for (int b = 0; b < 7; b++) begin
        if (v7[b]) ones++;
      end
      if (ones == 3 && found < 32) begin
        col_table[found] = v7;
        found++;
      end
    end
    for (int j = 0; j < 7; j++) begin
      col_table[32+j] = 7'(1 << j);
    end
    value_errors = 0;
    order_errors = 0;
    // Counters start at zero out of reset
    exp_ce_count = '0;
    exp_due_count = '0;
    idle = 1'b1;
  end

  // Expected decoder result for one sent item
  function automatic ecc_pkg::ecc_dec_result_t predict(input logic [31:0] data,
                                                       input ecc_pkg::ecc_inj_t inj);
    logic [38:0]              word;
    logic [6:0]               syn;
    int                       hit;
    ecc_pkg::ecc_dec_result_t res;
    word = {7'b0, data};
    for (int i = 0; i < 32; i++) begin
      if (data[i]) word[38:32] ^= col_table[i];
    end
    if (inj.mode != ecc_pkg::inj_none) word[inj.bit0] = ~word[inj.bit0];
    if (inj.mode == ecc_pkg::inj_double) word[inj.bit1] = ~word[inj.bit1];
    // Syndrome as XOR of the columns of all set bits
    syn = '0;
    for (int k = 0; k < 39; k++) begin
      if (word[k]) syn ^= col_table[k];
    end
    hit = -1;
    for (int k = 0; k < 39; k++) begin
      if (syn != '0 && syn == col_table[k]) hit = k;
    end
    res.data = word[31:0];
    res.syndrome = syn;
    res.ce = (hit >= 0);
    res.due = (syn != '0) && (hit < 0);
    if (hit >= 0 && hit < 32) res.data[hit] = ~res.data[hit];
    return res;
  endfunction

  task automatic value_mismatch(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
    $display("** Error at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
    value_errors++;
  endtask

  // Sample on the falling edge, away from the driving edge
  always @(negedge clk) begin : compare
    ecc_pkg::ecc_dec_result_t exp_res;
    pending_t                 item;
    logic                     ce_evt;
    logic                     due_evt;
    ce_evt = 1'b0;
    due_evt = 1'b0;
    if (ce_count !== exp_ce_count) value_mismatch("ce_count", 64'(ce_count), 64'(exp_ce_count));
    if (due_count !== exp_due_count) begin
      value_mismatch("due_count", 64'(due_count), 64'(exp_due_count));
    end
    if (!arst_n) begin
      pending_q.delete();
      cycle = 0;
      exp_ce_count = '0;
      exp_due_count = '0;
      if (out_valid !== 1'b0) value_mismatch("out_valid", 64'(out_valid), 64'd0);
    end else begin
      cycle++;
      if (out_valid === 1'b1) begin
        if (pending_q.size() == 0) begin
          $display("Checker: out_valid at %0t with no item in flight", $time);
          order_errors++;
        end else begin
          item = pending_q.pop_front();
          if (item.due_cycle != cycle) begin
            $display("Checker: result at %0t arrived %0d cycles late", $time,
                     int'(cycle) - int'(item.due_cycle));
            order_errors++;
          end
          exp_res = predict(item.data, item.inj);
          ce_evt = exp_res.ce;
          due_evt = exp_res.due;
          if (out_result.data !== exp_res.data) begin
            value_mismatch("out_result.data", 64'(out_result.data), 64'(exp_res.data));
          end
          if (out_result.syndrome !== exp_res.syndrome) begin
            value_mismatch("out_result.syndrome", 64'(out_result.syndrome),
                           64'(exp_res.syndrome));
          end
          if (out_result.ce !== exp_res.ce) begin
            value_mismatch("out_result.ce", 64'(out_result.ce), 64'(exp_res.ce));
          end
          if (out_result.due !== exp_res.due) begin
            value_mismatch("out_result.due", 64'(out_result.due), 64'(exp_res.due));
          end
        end
      end else if (pending_q.size() != 0 && pending_q[0].due_cycle <= cycle) begin
        $display("Checker: no out_valid at %0t for an item that was due", $time);
        order_errors++;
        pending_q.delete(0);
      end
      // Counter model for the next edge, clear wins
      if (clear) begin
        exp_ce_count = '0;
        exp_due_count = '0;
      end else begin
        if (ce_evt && exp_ce_count != '1) exp_ce_count++;
        if (due_evt && exp_due_count != '1) exp_due_count++;
      end
      if (in_valid) pending_q.push_back({in_data, in_inj, cycle + 32'd4});
    end
    idle = (pending_q.size() == 0);
  end

  always @(posedge report) begin
    $display("Errors: %0d value mismatches, %0d timing errors", value_errors, order_errors);
  end

endmodule

//--- tb_ecc_secded_path.sv
`timescale 1ns/1ps

module tb_ecc_secded_path;

  logic                     clk;
  logic                     arst_n;
  logic                     in_valid;
  logic [31:0]              in_data;
  ecc_pkg::ecc_inj_t        in_inj;
  logic                     clear;
  logic                     out_valid;
  ecc_pkg::ecc_dec_result_t out_result;
  logic [15:0]              ce_count;
  logic [15:0]              due_count;
  logic                     report;
  logic                     idle;
  int unsigned              error_count;
  integer                   seed;
  bit                       ok;

  tb_clock_gen i_clock_gen (.clk, .arst_n);

  ecc_secded_path i_dut (
    .clk, .arst_n, .in_valid, .in_data, .in_inj, .clear,
    .out_valid, .out_result, .ce_count, .due_count
  );

  tb_ecc_checker i_checker (
    .clk, .arst_n, .in_valid, .in_data, .in_inj, .clear, .out_valid,
    .out_result, .ce_count, .due_count, .report, .idle, .error_count
  );

  // One item on the next rising edge
  task automatic send_item(input logic [31:0] data, input ecc_pkg::ecc_inj_mode_e mode,
                           input logic [5:0] b0, input logic [5:0] b1, input bit clr);
    @(posedge clk);
    in_valid <= 1'b1;
    in_data <= data;
    in_inj.mode <= mode;
    in_inj.bit0 <= b0;
    in_inj.bit1 <= b1;
    clear <= clr;
  endtask

  task automatic idle_cycles(input int unsigned n, input bit clr);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
      clear <= clr;
    end
  endtask

  // Random mode, two distinct indices below 39
  task automatic send_random(input bit clr);
    logic [31:0] d;
    int unsigned m;
    logic [5:0]  b0;
    logic [5:0]  b1;
    d = $random(seed);
    m = $unsigned($random(seed)) % 3;
    b0 = 6'($unsigned($random(seed)) % 39);
    b1 = 6'((b0 + 1 + $unsigned($random(seed)) % 38) % 39);
    send_item(d, ecc_pkg::ecc_inj_mode_e'(m[1:0]), b0, b1, clr);
  endtask

  task automatic wait_reset_release(output bit done);
    int unsigned n;
    done = 1'b0;
    n = 0;
    while (!done && n < 100) begin
      @(posedge clk);
      done = arst_n;
      n++;
    end
    if (!done) $display("Timeout: reset was never released");
  endtask

  task automatic wait_drain(output bit done);
    int unsigned n;
    done = 1'b0;
    n = 0;
    while (!done && n < 64) begin
      @(posedge clk);
      done = idle;
      n++;
    end
    if (!done) $display("Timeout: results still missing after the input went idle");
    // Counters settle one cycle after the last result
    repeat (2) @(posedge clk);
  endtask

  initial begin
    int unsigned burst_len;
    seed = 32'hb9ef_f8a0;
    in_valid = 1'b0;
    in_data = '0;
    in_inj = '0;
    clear = 1'b0;
    report = 1'b0;
    wait_reset_release(ok);
    if (ok) begin
      // Idle input, no output expected
      idle_cycles(6, 1'b0);
      // Clean words back to back
      for (int i = 0; i < 8; i++) send_item($random(seed), ecc_pkg::inj_none, 6'd0, 6'd1, 1'b0);
      // Every single-bit position
      for (int k = 0; k < 39; k++) begin
        send_item($random(seed), ecc_pkg::inj_single, 6'(k), 6'((k + 1) % 39), 1'b0);
      end
      // Neighbouring double flips
      for (int k = 0; k < 39; k++) begin
        send_item($random(seed), ecc_pkg::inj_double, 6'(k), 6'((k + 1) % 39), 1'b0);
      end
      idle_cycles(6, 1'b0);
      idle_cycles(1, 1'b1);
      idle_cycles(2, 1'b0);
      // Random bursts with gaps, clear now and then
      for (int b = 0; b < 40; b++) begin
        burst_len = 1 + $unsigned($random(seed)) % 8;
        for (int j = 0; j < int'(burst_len); j++) begin
          send_random($unsigned($random(seed)) % 23 == 0);
        end
        idle_cycles($unsigned($random(seed)) % 4, 1'b0);
      end
      idle_cycles(1, 1'b0);
      wait_drain(ok);
    end
    report = 1'b1;
    #1;
    if (ok && error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- ecc_secded_path.f
ecc_pkg.sv
ecc_secded_encoder.sv
ecc_error_injector.sv
ecc_secded_decoder.sv
ecc_error_counters.sv
ecc_secded_path.sv
tb_clock_gen.sv
tb_ecc_checker.sv
tb_ecc_secded_path.sv

//--- Makefile
BIN := obj_dir/Vtb_ecc_secded_path
SRCS := $(shell cat ecc_secded_path.f)

.PHONY: all run clean

all: $(BIN)

$(BIN): ecc_secded_path.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_ecc_secded_path -Mdir obj_dir -f ecc_secded_path.f

run: $(BIN)
	./$(BIN) | tee sim.log
	@grep -q "Test completed successfully" sim.log
	@! grep -q "Test failed" sim.log

clean:
	rm -rf obj_dir sim.log
